// File: sources.f
cpuPkg.sv
instructionFetch.sv
controlUnit.sv
registerFile.sv
alu.sv
dataMemory.sv
cpu.sv
clockGen.sv
cpuTb.sv

// File: runSim.sh
#!/bin/bash
# Build with Verilator, run, and decide pass or fail from the log

verilator --binary --timing --top-module cpuTb -f sources.f -o cpuSim > build.log 2>&1 \
	&& ./obj_dir/cpuSim > sim.log 2>&1 \
	|| { echo "Build or simulation failed, see build.log and sim.log"; exit 1; }

grep -qx "TESTS PASSED" sim.log \
	&& { echo "Simulation passed"; exit 0; } \
	|| { echo "Simulation failed, see sim.log"; exit 1; }

// File: cpuTb.sv
// Testbench top with instruction memory model, directed tests, compare tasks and watchdog
`timescale 1ns/1ps

module cpuTb;

	// Cycle budget per test, reset included
	localparam int resetCycles = 3;
	localparam int seqCycles = 8;
	localparam int aluCycles = 14;
	localparam int zeroCycles = 4;
	localparam int memCycles = 10;
	localparam int branchCycles = 8;
	localparam int jumpCycles = 6;
	localparam int totalCycles = 6 * resetCycles + seqCycles + aluCycles + zeroCycles
		+ memCycles + branchCycles + jumpCycles;
	localparam int timeoutNs = totalCycles * 4 + 200;

	logic              clk;
	logic              reset;
	cpuPkg::instrWordT instruction;
	logic [31:0]       pc;
	logic              storeValid;
	cpuPkg::storeBusT  store;

	// Program image, zero words decode as no-ops
	cpuPkg::instrWordT prog [64];
	cpuPkg::storeBusT  pending [$];
	int                errors;
	integer            seed;

	clockGen clock (
		.clk (clk)
	);

	cpu #(
		.dataWords (64)
	) uut (
		.clk         (clk),
		.reset       (reset),
		.instruction (instruction),
		.pc          (pc),
		.storeValid  (storeValid),
		.store       (store)
	);

	// Instruction memory read, outside the image is a no-op
	function automatic cpuPkg::instrWordT fetchWord(logic [31:0] addr);
		if (addr[31:8] != 24'd0) begin
			return '0;
		end
		return prog[addr[7:2]];
	endfunction

	function automatic cpuPkg::instrWordT encodeR(cpuPkg::functT funct, logic [4:0] rs,
		logic [4:0] rt, logic [4:0] rd);
		cpuPkg::instrWordT w;
		w.rType.opcode = cpuPkg::opRType;
		w.rType.rs = rs;
		w.rType.rt = rt;
		w.rType.rd = rd;
		w.rType.shamt = 5'd0;
		w.rType.funct = funct;
		return w;
	endfunction

	function automatic cpuPkg::instrWordT encodeI(cpuPkg::opcodeT op, logic [4:0] rs,
		logic [4:0] rt, logic [15:0] imm);
		cpuPkg::instrWordT w;
		w.iType.opcode = op;
		w.iType.rs = rs;
		w.iType.rt = rt;
		w.iType.imm = imm;
		return w;
	endfunction

	function automatic cpuPkg::instrWordT encodeJ(logic [25:0] target);
		cpuPkg::instrWordT w;
		w.jType.opcode = cpuPkg::opJ;
		w.jType.target = target;
		return w;
	endfunction

	function automatic logic [31:0] signExtend(logic [15:0] imm);
		return {{16{imm[15]}}, imm};
	endfunction

	task automatic checkStore(cpuPkg::storeBusT expected, cpuPkg::storeBusT actual);
		if (actual !== expected) begin
			errors++;
			$display("Fail at %0.1f ns: store expected %h actual %h", $realtime, expected,
				actual);
		end
	endtask

	task automatic checkPc(logic [31:0] expected, logic [31:0] actual);
		if (actual !== expected) begin
			errors++;
			$display("Fail at %0.1f ns: pc expected %h actual %h", $realtime, expected, actual);
		end
	endtask

	task automatic expectStore(logic [31:0] address, logic [31:0] data);
		cpuPkg::storeBusT s;
		s.address = address;
		s.data = data;
		pending.push_back(s);
	endtask

	// Hold reset for two edges, image and expectations cleared
	task automatic applyReset();
		@(posedge clk);
		#0.5;
		reset = 1'b1;
		instruction = '0;
		pending.delete();
		for (int i = 0; i < 64; i++) begin
			prog[i] = '0;
		end
	endtask

	task automatic releaseReset();
		repeat (2) @(posedge clk);
		#0.5;
		reset = 1'b0;
		instruction = fetchWord(pc);
		checkPc(32'd0, pc);
	endtask

	// One instruction, store sampled at the falling edge
	task automatic stepCycle();
		cpuPkg::storeBusT exp;
		#1.5;
		if (storeValid === 1'b1) begin
			if (pending.size() == 0) begin
				errors++;
				$display("Store strobe at %0.1f ns appeared when none was expected", $realtime);
			end else begin
				exp = pending.pop_front();
				checkStore(exp, store);
			end
		end
		@(posedge clk);
		#0.5;
		instruction = fetchWord(pc);
	endtask

	task automatic runCycles(int n);
		for (int i = 0; i < n; i++) begin
			stepCycle();
		end
		if (pending.size() != 0) begin
			errors += pending.size();
			$display("%0d expected stores never arrived by %0.1f ns", pending.size(), $realtime);
			pending.delete();
		end
	endtask

	task automatic testSequential();
		applyReset();
		releaseReset();
		for (int i = 1; i <= seqCycles; i++) begin
			stepCycle();
			checkPc(32'(i * 4), pc);
		end
		runCycles(0);
	endtask

	task automatic testArithmetic();
		logic [15:0] a;
		logic [15:0] b;
		logic [31:0] sa;
		logic [31:0] sb;
		applyReset();
		a = 16'($random(seed));
		b = 16'($random(seed));
		sa = signExtend(a);
		sb = signExtend(b);
		prog[0] = encodeI(cpuPkg::opAddi, 5'd0, 5'd1, a);
		prog[1] = encodeI(cpuPkg::opAddi, 5'd0, 5'd2, b);
		prog[2] = encodeR(cpuPkg::functAdd, 5'd1, 5'd2, 5'd3);
		prog[3] = encodeR(cpuPkg::functSub, 5'd1, 5'd2, 5'd4);
		prog[4] = encodeR(cpuPkg::functAnd, 5'd1, 5'd2, 5'd5);
		prog[5] = encodeR(cpuPkg::functOr, 5'd1, 5'd2, 5'd6);
		prog[6] = encodeR(cpuPkg::functSlt, 5'd1, 5'd2, 5'd7);
		for (int i = 0; i < 5; i++) begin
			prog[7 + i] = encodeI(cpuPkg::opSw, 5'd0, 5'(3 + i), 16'(4 * i));
		end
		expectStore(32'd0, sa + sb);
		expectStore(32'd4, sa - sb);
		expectStore(32'd8, sa & sb);
		expectStore(32'd12, sa | sb);
		expectStore(32'd16, ($signed(sa) < $signed(sb)) ? 32'd1 : 32'd0);
		releaseReset();
		runCycles(aluCycles);
	endtask

	task automatic testRegisterZero();
		applyReset();
		prog[0] = encodeI(cpuPkg::opAddi, 5'd0, 5'd0, 16'h1234);
		prog[1] = encodeI(cpuPkg::opSw, 5'd0, 5'd0, 16'h0008);
		expectStore(32'd8, 32'd0);
		releaseReset();
		runCycles(zeroCycles);
	endtask

	task automatic testLoadStore();
		logic [15:0] v1;
		logic [15:0] v2;
		applyReset();
		v1 = 16'($random(seed));
		v2 = 16'($random(seed));
		prog[0] = encodeI(cpuPkg::opAddi, 5'd0, 5'd1, v1);
		prog[1] = encodeI(cpuPkg::opAddi, 5'd0, 5'd2, v2);
		prog[2] = encodeI(cpuPkg::opSw, 5'd0, 5'd1, 16'h0010);
		// 0x104 wraps onto word 1 of 64
		prog[3] = encodeI(cpuPkg::opSw, 5'd0, 5'd2, 16'h0104);
		prog[4] = encodeI(cpuPkg::opLw, 5'd0, 5'd5, 16'h0010);
		prog[5] = encodeI(cpuPkg::opLw, 5'd0, 5'd6, 16'h0004);
		prog[6] = encodeI(cpuPkg::opSw, 5'd0, 5'd5, 16'h0020);
		prog[7] = encodeI(cpuPkg::opSw, 5'd0, 5'd6, 16'h0024);
		expectStore(32'h10, signExtend(v1));
		expectStore(32'h104, signExtend(v2));
		expectStore(32'h20, signExtend(v1));
		expectStore(32'h24, signExtend(v2));
		releaseReset();
		runCycles(memCycles);
	endtask

	task automatic testBranch();
		applyReset();
		prog[0] = encodeI(cpuPkg::opAddi, 5'd0, 5'd1, 16'd5);
		prog[1] = encodeI(cpuPkg::opAddi, 5'd0, 5'd2, 16'd5);
		// Taken, skips word 3
		prog[2] = encodeI(cpuPkg::opBeq, 5'd1, 5'd2, 16'd1);
		prog[3] = encodeI(cpuPkg::opSw, 5'd0, 5'd1, 16'd0);
		// Not taken since r1 is 5
		prog[4] = encodeI(cpuPkg::opBeq, 5'd1, 5'd0, 16'd5);
		prog[5] = encodeI(cpuPkg::opSw, 5'd0, 5'd2, 16'd4);
		expectStore(32'd4, 32'd5);
		releaseReset();
		repeat (3) stepCycle();
		checkPc(32'd8 + 32'd4 + 32'd4, pc);
		stepCycle();
		checkPc(32'd16 + 32'd4, pc);
		runCycles(branchCycles - 4);
	endtask

	task automatic testJump();
		applyReset();
		prog[0] = encodeI(cpuPkg::opAddi, 5'd0, 5'd1, 16'd7);
		prog[1] = encodeJ(26'd8);
		// Never reached
		prog[2] = encodeI(cpuPkg::opSw, 5'd0, 5'd1, 16'd0);
		prog[8] = encodeI(cpuPkg::opSw, 5'd0, 5'd1, 16'd12);
		expectStore(32'd12, 32'd7);
		releaseReset();
		repeat (2) stepCycle();
		checkPc(32'd32, pc);
		runCycles(jumpCycles - 2);
	endtask

	// Watchdog
	initial begin
		#(timeoutNs);
		$display("Timeout after %0d ns, tests did not finish", timeoutNs);
		$display("TESTS FAILED");
		$finish;
	end

	initial begin
		reset = 1'b1;
		instruction = '0;
		errors = 0;
		seed = 32'ha3ae;
		testSequential();
		testArithmetic();
		testRegisterZero();
		testLoadStore();
		testBranch();
		testJump();
		$display("Checks complete with %0d errors", errors);
		if (errors == 0) begin
			$display("TESTS PASSED");
		end else begin
			$display("TESTS FAILED");
		end
		$finish;
	end

endmodule

// File: clockGen.sv
// Testbench clock source with a 4 ns period
`timescale 1ns/1ps

module clockGen #(
	parameter real period = 4.0
) (
	output logic clk
);

	// Starts low, first rising edge at half a period
	initial begin
		clk = 1'b0;
	end

	always #(period / 2.0) clk = ~clk;

endmodule

// File: cpu.sv
// Single-cycle MIPS core top level with fetch, decode, register fetch, execute, memory and write-back
`timescale 1ns/1ps

module cpu #(
	parameter int dataWords = cpuPkg::dataWords
) (
	input  logic              clk,
	input  logic              reset,
	input  cpuPkg::instrWordT instruction,
	output logic [31:0]       pc,
	output logic              storeValid,
	output cpuPkg::storeBusT  store
);

	cpuPkg::controlT ctrl;

	// Register fetch
	logic [31:0] readA;
	logic [31:0] readB;

	// Execute
	logic [31:0] extendedImm;
	logic [31:0] operandB;
	logic [31:0] aluResult;
	logic        zero;

	// Memory and write-back
	logic [31:0] memReadData;
	logic [31:0] writeBackData;
	logic [4:0]  writeAddr;

	// Fetch, pc presented to external instruction memory
	instructionFetch fetch (
		.clk   (clk),
		.reset (reset),
		.instr (instruction),
		.ctrl  (ctrl),
		.zero  (zero),
		.pc    (pc)
	);

	// Decode, runs beside register fetch
	controlUnit control (
		.instr (instruction),
		.ctrl  (ctrl)
	);

	// rd for R-type, rt for immediate forms
	assign writeAddr = ctrl.regDestRd ? instruction.rType.rd : instruction.iType.rt;

	registerFile registers (
		.clk         (clk),
		.reset       (reset),
		.readAddrA   (instruction.iType.rs),
		.readAddrB   (instruction.iType.rt),
		.writeAddr   (writeAddr),
		.writeData   (writeBackData),
		.writeEnable (ctrl.regWrite),
		.readA       (readA),
		.readB       (readB)
	);

	// Sign extended immediate as second operand
	assign extendedImm = {{16{instruction.iType.imm[15]}}, instruction.iType.imm};
	assign operandB    = ctrl.aluSrcImm ? extendedImm : readB;

	alu execute (
		.operandA (readA),
		.operandB (operandB),
		.op       (ctrl.aluOp),
		.result   (aluResult),
		.zero     (zero)
	);

	// ALU result is the byte address for lw and sw
	dataMemory #(
		.dataWords (dataWords)
	) memory (
		.clk         (clk),
		.reset       (reset),
		.address     (aluResult),
		.writeData   (readB),
		.writeEnable (ctrl.memWrite),
		.readData    (memReadData)
	);

	// Write-back select
	assign writeBackData = ctrl.memToReg ? memReadData : aluResult;

	// Store strobe, one cycle per sw, held low in reset
	assign storeValid    = ctrl.memWrite & ~reset;
	// Payload zero outside a store
	assign store.address = storeValid ? aluResult : 32'd0;
	assign store.data    = storeValid ? readB : 32'd0;

endmodule

// File: dataMemory.sv
// Word-addressed data memory, combinational read and clocked write
`timescale 1ns/1ps

module dataMemory #(
	parameter int dataWords = cpuPkg::dataWords
) (
	input  logic        clk,
	input  logic        reset,
	input  logic [31:0] address,
	input  logic [31:0] writeData,
	input  logic        writeEnable,
	output logic [31:0] readData
);

	localparam int indexBits = $clog2(dataWords);

	logic [31:0]          mem [dataWords];
	logic [indexBits-1:0] index;

	// Byte address to word index, upper bits drop off so it wraps
	assign index = address[indexBits+1:2];

	always_ff @(posedge clk) begin
		if (reset) begin
			for (int i = 0; i < dataWords; i++) begin
				mem[i] <= 32'd0;
			end
		end else if (writeEnable) begin
			mem[index] <= writeData;
		end
	end

	// Read in the same cycle
	assign readData = mem[index];

endmodule

// File: alu.sv
// 32-bit ALU with add, sub, and, or, signed set-less-than and zero flag
`timescale 1ns/1ps

module alu (
	input  logic [31:0]   operandA,
	input  logic [31:0]   operandB,
	input  cpuPkg::aluOpT op,
	output logic [31:0]   result,
	output logic          zero
);

	logic [31:0] sum;
	logic [31:0] difference;
	logic        lessThan;

	// Shared arithmetic
	assign sum        = operandA + operandB;
	assign difference = operandA - operandB;

	// Signed compare
	assign lessThan = $signed(operandA) < $signed(operandB);

	always_comb begin
		case (op)
			cpuPkg::aluAdd: begin
				result = sum;
			end
			cpuPkg::aluSub: begin
				result = difference;
			end
			cpuPkg::aluAnd: begin
				result = operandA & operandB;
			end
			cpuPkg::aluOr: begin
				result = operandA | operandB;
			end
			cpuPkg::aluSlt: begin
				// One in bit zero when less
				result = {31'd0, lessThan};
			end
			default: begin
				result = 32'd0;
			end
		endcase
	end

	// Zero flag, used by beq
	assign zero = (result == 32'd0);

endmodule

// File: registerFile.sv
// Thirty-two entry register file, two read ports, one write port, register zero fixed at zero
`timescale 1ns/1ps

module registerFile (
	input  logic        clk,
	input  logic        reset,
	input  logic [4:0]  readAddrA,
	input  logic [4:0]  readAddrB,
	input  logic [4:0]  writeAddr,
	input  logic [31:0] writeData,
	input  logic        writeEnable,
	output logic [31:0] readA,
	output logic [31:0] readB
);

	logic [31:0] regs [32];
	logic        writeAllowed;

	// Writes to register zero are dropped
	assign writeAllowed = writeEnable & (writeAddr != 5'd0);

	// Write port, whole file cleared on reset
	always_ff @(posedge clk) begin
		if (reset) begin
			for (int i = 0; i < 32; i++) begin
				regs[i] <= 32'd0;
			end
		end else if (writeAllowed) begin
			regs[writeAddr] <= writeData;
		end
	end

	// Asynchronous reads
	// register zero forced to zero on both ports
	assign readA = (readAddrA == 5'd0) ? 32'd0 : regs[readAddrA];
	assign readB = (readAddrB == 5'd0) ? 32'd0 : regs[readAddrB];

endmodule

// File: controlUnit.sv
// Opcode and function decode into the control struct
`timescale 1ns/1ps

module controlUnit (
	input  cpuPkg::instrWordT instr,
	output cpuPkg::controlT   ctrl
);

	always_comb begin
		// Everything inactive, also the no-op for unknown codes
		ctrl = '0;
		case (instr.rType.opcode)
			cpuPkg::opRType: begin
				// Function code picks the ALU command
				case (instr.rType.funct)
					cpuPkg::functAdd: begin
						ctrl.regWrite  = 1'b1;
						ctrl.regDestRd = 1'b1;
						ctrl.aluOp     = cpuPkg::aluAdd;
					end
					cpuPkg::functSub: begin
						ctrl.regWrite  = 1'b1;
						ctrl.regDestRd = 1'b1;
						ctrl.aluOp     = cpuPkg::aluSub;
					end
					cpuPkg::functAnd: begin
						ctrl.regWrite  = 1'b1;
						ctrl.regDestRd = 1'b1;
						ctrl.aluOp     = cpuPkg::aluAnd;
					end
					cpuPkg::functOr: begin
						ctrl.regWrite  = 1'b1;
						ctrl.regDestRd = 1'b1;
						ctrl.aluOp     = cpuPkg::aluOr;
					end
					cpuPkg::functSlt: begin
						ctrl.regWrite  = 1'b1;
						ctrl.regDestRd = 1'b1;
						ctrl.aluOp     = cpuPkg::aluSlt;
					end
					default: begin
						// Unknown function, left as no-op
						ctrl = '0;
					end
				endcase
			end
			cpuPkg::opAddi: begin
				ctrl.regWrite  = 1'b1;
				ctrl.aluSrcImm = 1'b1;
				ctrl.aluOp     = cpuPkg::aluAdd;
			end
			cpuPkg::opLw: begin
				// Address is rs plus offset, result from memory into rt
				ctrl.regWrite  = 1'b1;
				ctrl.aluSrcImm = 1'b1;
				ctrl.memToReg  = 1'b1;
				ctrl.aluOp     = cpuPkg::aluAdd;
			end
			cpuPkg::opSw: begin
				ctrl.aluSrcImm = 1'b1;
				ctrl.memWrite  = 1'b1;
				ctrl.aluOp     = cpuPkg::aluAdd;
			end
			cpuPkg::opBeq: begin
				// Compare by subtraction
				ctrl.isBranch = 1'b1;
				ctrl.aluOp    = cpuPkg::aluSub;
			end
			cpuPkg::opJ: begin
				ctrl.isJump = 1'b1;
			end
			default: begin
				ctrl = '0;
			end
		endcase
	end

endmodule

// File: instructionFetch.sv
// Program counter register with sequential, branch and jump next-address selection
`timescale 1ns/1ps

module instructionFetch (
	input  logic               clk,
	input  logic               reset,
	input  cpuPkg::instrWordT  instr,
	input  cpuPkg::controlT    ctrl,
	input  logic               zero,
	output logic [31:0]        pc
);

	logic [31:0] pcPlus4;
	logic [31:0] branchOffset;
	logic [31:0] branchTarget;
	logic [31:0] jumpTarget;
	logic        branchTaken;
	logic [31:0] nextPc;

	// Sequential address
	assign pcPlus4 = pc + 32'd4;

	// Word offset, sign extended and scaled to bytes
	assign branchOffset = {{14{instr.iType.imm[15]}}, instr.iType.imm, 2'b00};
	assign branchTarget = pcPlus4 + branchOffset;

	// Region bits come from the incremented pc
	assign jumpTarget = {pcPlus4[31:28], instr.jType.target, 2'b00};

	// beq needs equal operands, so the ALU difference is zero
	assign branchTaken = ctrl.isBranch & zero;

	// Jump wins, then branch, else fall through
	always_comb begin
		if (ctrl.isJump) begin
			nextPc = jumpTarget;
		end else if (branchTaken) begin
			nextPc = branchTarget;
		end else begin
			nextPc = pcPlus4;
		end
	end

	// PC register
	always_ff @(posedge clk) begin
		if (reset) begin
			pc <= 32'd0;
		end else begin
			pc <= nextPc;
		end
	end

endmodule

// File: cpuPkg.sv
// Instruction formats, opcode and function codes, ALU commands, control and store-bus types
package cpuPkg;

	// Default data memory depth in words, a power of two
	parameter int dataWords = 64;

	// Primary opcodes of the supported subset
	typedef enum logic [5:0] {
		opRType = 6'h00,
		opJ     = 6'h02,
		opBeq   = 6'h04,
		opAddi  = 6'h08,
		opLw    = 6'h23,
		opSw    = 6'h2b
	} opcodeT;

	// R-type function codes
	typedef enum logic [5:0] {
		functAdd = 6'h20,
		functSub = 6'h22,
		functAnd = 6'h24,
		functOr  = 6'h25,
		functSlt = 6'h2a
	} functT;

	// ALU commands, lab ALU encoding
	typedef enum logic [2:0] {
		aluAdd = 3'd0,
		aluSub = 3'd1,
		aluSlt = 3'd3,
		aluAnd = 3'd4,
		aluOr  = 3'd7
	} aluOpT;

	// Register-register format
	typedef struct packed {
		opcodeT     opcode;
		logic [4:0] rs;
		logic [4:0] rt;
		logic [4:0] rd;
		logic [4:0] shamt;
		functT      funct;
	} rTypeT;

	// Immediate format, also loads, stores and branches
	typedef struct packed {
		opcodeT      opcode;
		logic [4:0]  rs;
		logic [4:0]  rt;
		logic [15:0] imm;
	} iTypeT;

	// Jump format
	typedef struct packed {
		opcodeT      opcode;
		logic [25:0] target;
	} jTypeT;

	// One fetched word, read in all three formats
	typedef union packed {
		rTypeT rType;
		iTypeT iType;
		jTypeT jType;
	} instrWordT;

	// Decoded control lines
	typedef struct packed {
		logic  regWrite;
		logic  regDestRd;
		logic  aluSrcImm;
		logic  memWrite;
		logic  memToReg;
		logic  isBranch;
		logic  isJump;
		aluOpT aluOp;
	} controlT;

	// Store strobe payload leaving the core
	typedef struct packed {
		logic [31:0] address;
		logic [31:0] data;
	} storeBusT;

endpackage
